//--- u712Config.svh
// U712 bridge timing constants and chip RAM address field positions
`ifndef U712_CONFIG_SVH
`define U712_CONFIG_SVH

////////////////////
// Register cycle
////////////////////

// Clocks that AS/UDS/LDS stay asserted toward Agnus
`define REG_STROBE_CYCLES 8

////////////////////
// Chip RAM timing
////////////////////

// RAS fall to CAS fall, in clk80 cycles
`define RAS_TO_CAS 2
// CAS low time before both strobes rise
`define CAS_CYCLES 3

// Row, column and bank bits inside the local bus address
`define ROW_MSB  19
`define ROW_LSB  9
`define COL_MSB  8
`define COL_LSB  1
`define BANK_BIT 20

`endif

//--- u712Pkg.sv
// U712 shared bus types for the local bus, Agnus side and chip RAM pins
`default_nettype none

package u712Pkg;

    // 68040 style local bus request, held by the master until tackN
    typedef struct packed {
        logic        tsN;
        logic        rnw;
        logic [1:0]  siz;
        logic [20:0] addr;
        logic        regSpaceN;
        logic        ramSpaceN;
    } cpuBusT;

    // Agnus DMA strobes, row/column address and chipset phase
    typedef struct packed {
        logic       dbrN;
        logic       ras0N;
        logic       ras1N;
        logic       casLN;
        logic       casUN;
        logic       aweN;
        logic [9:0] dra;
        logic       c1;
    } dmaBusT;

    // Chip RAM pins
    typedef struct packed {
        logic        rasN;
        logic        casN;
        logic        weN;
        logic        bank1;
        logic        bank0;
        logic        clkEn;
        logic        crcsN;
        logic        ramEnN;
        logic [10:0] cma;
    } ramCmdT;

    // 68000 style strobes toward Agnus registers
    typedef struct packed {
        logic asN;
        logic udsN;
        logic ldsN;
        logic regEnN;
    } regStrobeT;

    // Data buffer enables and directions, no spare bits
    typedef struct packed {
        logic dbDir;
        logic vbEnN;
        logic drdEnN;
        logic drdDir;
        logic dbEnN;
    } bufCtrlT;

    // Byte lanes, upper lane first, all active low
    typedef struct packed {
        logic cuubeN;
        logic cumbeN;
        logic clmbeN;
        logic cllbeN;
    } byteEnT;

endpackage

`default_nettype wire

//--- regCycle.sv
// Agnus register cycle sequencer making 68000 strobes aligned to the c1 phase
`timescale 1ns/10ps
`default_nettype none
`include "u712Config.svh"

module regCycle import u712Pkg::*; (
    input  logic      clk80,
    input  logic      rstN,
    input  cpuBusT    cpu,
    input  logic      c1,
    output regStrobeT strobe,
    output logic      regTack,
    output logic      regActive
);

    typedef enum logic [1:0] {
        IDLE,
        PHASE,
        STROBE
    } stateT;

    // Last clock with strobes low
    localparam logic [3:0] STROBE_LAST = 4'(`REG_STROBE_CYCLES - 1);
    // Two clocks of tail so tackN and the tsN release pass before idle
    localparam logic [3:0] CYCLE_LAST  = 4'(`REG_STROBE_CYCLES + 1);

    stateT      state;
    logic [3:0] holdCnt;
    logic       c1Q;
    logic       c1Rise;
    logic       byteAcc;

    ////////////////////
    // Phase detect
    ////////////////////

    // c1 low last clock, high now
    assign c1Rise    = ~c1Q & c1;
    // 68040 size 01 is a byte
    assign byteAcc   = (cpu.siz == 2'b01);
    assign regActive = (state != IDLE);

    ////////////////////
    // Sequencer
    ////////////////////

    always_ff @(posedge clk80) begin
        if (!rstN) begin
            state   <= IDLE;
            holdCnt <= '0;
            c1Q     <= 1'b0;
            strobe  <= '1;
            regTack <= 1'b0;
        end else begin
            c1Q     <= c1;
            regTack <= 1'b0;
            case (state)
                IDLE: begin
                    if (!cpu.tsN && !cpu.regSpaceN) begin
                        state <= PHASE;
                    end
                end
                PHASE: begin
                    // Strobes start on the edge after c1 rises
                    if (c1Rise) begin
                        state         <= STROBE;
                        holdCnt       <= '0;
                        strobe.asN    <= 1'b0;
                        strobe.regEnN <= 1'b0;
                        // Even byte on the upper lane, odd byte on the lower
                        strobe.udsN   <= byteAcc & cpu.addr[0];
                        strobe.ldsN   <= byteAcc & ~cpu.addr[0];
                    end
                end
                STROBE: begin
                    holdCnt <= holdCnt + 4'd1;
                    if (holdCnt == STROBE_LAST) begin
                        strobe  <= '1;
                        regTack <= 1'b1;
                    end
                    if (holdCnt == CYCLE_LAST) begin
                        state <= IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- chipRam.sv
// Chip RAM controller running CPU RAS/CAS cycles and forwarding Agnus DMA
`timescale 1ns/10ps
`default_nettype none
`include "u712Config.svh"

module chipRam import u712Pkg::*; (
    input  logic   clk80,
    input  logic   rstN,
    input  cpuBusT cpu,
    input  dmaBusT dma,
    output ramCmdT ram,
    output logic   cpuTack,
    output logic   cpuCycle,
    output logic   dmaCycle
);

    typedef enum logic {
        IDLE,
        CPU_RUN
    } stateT;

    // Sequence points, counted from the start clock
    localparam logic [3:0] RAS_START = 4'd0;
    localparam logic [3:0] CAS_START = 4'(`RAS_TO_CAS);
    localparam logic [3:0] CAS_END   = 4'(`RAS_TO_CAS + `CAS_CYCLES);
    // Tail covers tackN and the tsN release
    localparam logic [3:0] CYCLE_END = 4'(`RAS_TO_CAS + `CAS_CYCLES + 2);

    // All strobes high, clock off, chip deselected
    localparam ramCmdT RAM_IDLE = '{
        rasN:   1'b1,
        casN:   1'b1,
        weN:    1'b1,
        bank1:  1'b0,
        bank0:  1'b0,
        clkEn:  1'b0,
        crcsN:  1'b1,
        ramEnN: 1'b1,
        cma:    11'd0
    };

    stateT      state;
    logic [3:0] seqCnt;
    logic       cpuReq;

    ////////////////////
    // Arbitration
    ////////////////////

    // CPU only gets the RAM while Agnus holds dbrN high
    assign cpuReq   = ~cpu.tsN & ~cpu.ramSpaceN & dma.dbrN;
    assign cpuCycle = (state == CPU_RUN);
    assign dmaCycle = (state == IDLE) & ~dma.dbrN;

    always_ff @(posedge clk80) begin
        if (!rstN) begin
            state   <= IDLE;
            seqCnt  <= '0;
            cpuTack <= 1'b0;
            ram     <= RAM_IDLE;
        end else begin
            cpuTack <= 1'b0;
            case (state)
                IDLE: begin
                    if (cpuReq) begin
                        state      <= CPU_RUN;
                        seqCnt     <= '0;
                        ram        <= RAM_IDLE;
                        ram.clkEn  <= 1'b1;
                        ram.crcsN  <= 1'b0;
                        ram.ramEnN <= 1'b0;
                    end else if (!dma.dbrN) begin
                        // Agnus owns the RAM, pins follow one clock late
                        ram.rasN   <= dma.ras0N & dma.ras1N;
                        ram.bank0  <= ~dma.ras0N;
                        ram.bank1  <= ~dma.ras1N;
                        ram.casN   <= dma.casLN & dma.casUN;
                        ram.weN    <= dma.aweN;
                        ram.cma    <= {1'b0, dma.dra};
                        ram.clkEn  <= 1'b1;
                        ram.crcsN  <= 1'b0;
                        ram.ramEnN <= 1'b1;
                    end else begin
                        ram <= RAM_IDLE;
                    end
                end
                CPU_RUN: begin
                    seqCnt <= seqCnt + 4'd1;
                    // Row phase
                    if (seqCnt == RAS_START) begin
                        ram.rasN  <= 1'b0;
                        ram.cma   <= cpu.addr[`ROW_MSB:`ROW_LSB];
                        ram.bank1 <= cpu.addr[`BANK_BIT];
                        ram.bank0 <= ~cpu.addr[`BANK_BIT];
                    end
                    // Column phase, column zero extended
                    if (seqCnt == CAS_START) begin
                        ram.casN <= 1'b0;
                        ram.cma  <= 11'(cpu.addr[`COL_MSB:`COL_LSB]);
                        ram.weN  <= cpu.rnw;
                    end
                    // Both strobes up together with the ack
                    if (seqCnt == CAS_END) begin
                        ram.rasN <= 1'b1;
                        ram.casN <= 1'b1;
                        ram.weN  <= 1'b1;
                        cpuTack  <= 1'b1;
                    end
                    if (seqCnt == CYCLE_END) begin
                        state <= IDLE;
                        ram   <= RAM_IDLE;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

endmodule

`default_nettype wire

//--- byteEnable.sv
// Byte lane enable decode from CPU size and address or from Agnus CAS strobes
`timescale 1ns/10ps
`default_nettype none

module byteEnable import u712Pkg::*; (
    input  cpuBusT cpu,
    input  dmaBusT dma,
    input  logic   cpuCycle,
    input  logic   dmaCycle,
    output byteEnT be
);

    always_comb begin
        be = '1;
        if (cpuCycle) begin
            case (cpu.siz)
                // Byte, lane 0 is the upper lane
                2'b01: begin
                    case (cpu.addr[1:0])
                        2'd0:    be.cuubeN = 1'b0;
                        2'd1:    be.cumbeN = 1'b0;
                        2'd2:    be.clmbeN = 1'b0;
                        default: be.cllbeN = 1'b0;
                    endcase
                end
                // Word, upper or lower pair
                2'b10: begin
                    if (!cpu.addr[1]) begin
                        be.cuubeN = 1'b0;
                        be.cumbeN = 1'b0;
                    end else begin
                        be.clmbeN = 1'b0;
                        be.cllbeN = 1'b0;
                    end
                end
                // Long and line
                default: be = '0;
            endcase
        end else if (dmaCycle) begin
            // Agnus is a 16 bit master, each CAS covers a lane pair
            be.cuubeN = dma.casUN;
            be.cumbeN = dma.casUN;
            be.clmbeN = dma.casLN;
            be.cllbeN = dma.casLN;
        end
    end

endmodule

`default_nettype wire

//--- busControl.sv
// Data buffer control and merged registered transfer acknowledge
`timescale 1ns/10ps
`default_nettype none

module busControl import u712Pkg::*; (
    input  logic    clk80,
    input  logic    rstN,
    input  logic    rnw,
    input  logic    regActive,
    input  logic    cpuCycle,
    input  logic    dmaCycle,
    input  logic    regTack,
    input  logic    cpuTack,
    output bufCtrlT bufCtrl,
    output logic    tackN
);

    ////////////////////
    // Buffers
    ////////////////////

    always_comb begin
        // Chip data bus open for any RAM access
        bufCtrl.dbEnN  = ~(cpuCycle | dmaCycle);
        // Local bus side only for CPU RAM cycles
        bufCtrl.vbEnN  = ~cpuCycle;
        // Register data path
        bufCtrl.drdEnN = ~regActive;
        // Direction turns around while Agnus drives
        bufCtrl.dbDir  = dmaCycle ? ~rnw : rnw;
        bufCtrl.drdDir = rnw;
    end

    ////////////////////
    // Termination
    ////////////////////

    // One clock low, the clock after either done pulse
    always_ff @(posedge clk80) begin
        if (!rstN) begin
            tackN <= 1'b1;
        end else begin
            tackN <= ~(regTack | cpuTack);
        end
    end

endmodule

`default_nettype wire

//--- u712Top.sv
// U712 chip RAM and chipset register bridge top level
`timescale 1ns/10ps
`default_nettype none

module u712Top import u712Pkg::*; (
    input  logic      clk80,
    input  logic      rstN,
    input  cpuBusT    cpu,
    input  dmaBusT    dma,
    output ramCmdT    ram,
    output regStrobeT strobe,
    output bufCtrlT   bufCtrl,
    output byteEnT    be,
    output logic      tackN
);

    logic regTack;
    logic regActive;
    logic cpuTack;
    logic cpuCycle;
    logic dmaCycle;

    ////////////////////
    // Register cycle
    ////////////////////

    regCycle uRegCycle (
        .clk80     (clk80),
        .rstN      (rstN),
        .cpu       (cpu),
        .c1        (dma.c1),
        .strobe    (strobe),
        .regTack   (regTack),
        .regActive (regActive)
    );

    ////////////////////
    // Chip RAM
    ////////////////////

    chipRam uChipRam (
        .clk80    (clk80),
        .rstN     (rstN),
        .cpu      (cpu),
        .dma      (dma),
        .ram      (ram),
        .cpuTack  (cpuTack),
        .cpuCycle (cpuCycle),
        .dmaCycle (dmaCycle)
    );

    // Lane decode
    byteEnable uByteEnable (
        .cpu      (cpu),
        .dma      (dma),
        .cpuCycle (cpuCycle),
        .dmaCycle (dmaCycle),
        .be       (be)
    );

    // Buffers and tackN
    busControl uBusControl (
        .clk80     (clk80),
        .rstN      (rstN),
        .rnw       (cpu.rnw),
        .regActive (regActive),
        .cpuCycle  (cpuCycle),
        .dmaCycle  (dmaCycle),
        .regTack   (regTack),
        .cpuTack   (cpuTack),
        .bufCtrl   (bufCtrl),
        .tackN     (tackN)
    );

endmodule

`default_nettype wire

//--- tbClock.sv
// Testbench clock and reset source, 20 ns clk80 with a 10 cycle reset
`timescale 1ns/10ps
`default_nettype none

module tbClock (
    output logic clk80,
    output logic rstN
);

    // 50 MHz stand-in for the board clock
    initial begin
        clk80 = 1'b0;
        forever #10 clk80 = ~clk80;
    end

    // Released just after the 10th rising edge
    initial begin
        rstN = 1'b0;
        repeat (10) @(posedge clk80);
        #1 rstN = 1'b1;
    end

endmodule

`default_nettype wire

//--- u712Tb.sv
// U712 bridge testbench with random traffic and a cycle model of every output
`timescale 1ns/10ps
`default_nettype none
`include "u712Config.svh"

module u712Tb import u712Pkg::*; ();

    localparam int NUM_TRANS   = 300;
    localparam int MAX_CYCLES  = NUM_TRANS * 40;
    // Edges from tsN sampled to tackN low
    localparam int RAM_LATENCY = 1 + `RAS_TO_CAS + `CAS_CYCLES + 1;

    logic      clk80;
    logic      rstN;
    cpuBusT    cpu;
    dmaBusT    dma;
    ramCmdT    ram;
    regStrobeT strobe;
    bufCtrlT   bufCtrl;
    byteEnT    be;
    logic      tackN;

    // Model state as of the last clock edge
    ramCmdT      mRam;
    regStrobeT   mStrobe;
    logic        mTackN;
    logic        mCpuCyc;
    logic        mRegAct;
    logic [31:0] rngState;
    logic        c1Last;
    int          cycleCnt;
    int          errors;
    int          checks;
    string       testName;

    tbClock clkGen (
        .clk80 (clk80),
        .rstN  (rstN)
    );

    u712Top uut (
        .clk80   (clk80),
        .rstN    (rstN),
        .cpu     (cpu),
        .dma     (dma),
        .ram     (ram),
        .strobe  (strobe),
        .bufCtrl (bufCtrl),
        .be      (be),
        .tackN   (tackN)
    );

    ////////////////////
    // Model helpers
    ////////////////////

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    task automatic drawRandom(output logic [31:0] value);
        rngState = xorshift(rngState);
        value = rngState;
    endtask

    // RAM pins with nothing running
    function automatic ramCmdT ramIdle();
        ramCmdT r;
        r = '0;
        r.rasN = 1'b1;
        r.casN = 1'b1;
        r.weN = 1'b1;
        r.crcsN = 1'b1;
        r.ramEnN = 1'b1;
        return r;
    endfunction

    // Agnus pins as they appear on the RAM one clock later
    function automatic ramCmdT forwarded(input dmaBusT d);
        ramCmdT r;
        r.rasN = ~(~d.ras0N | ~d.ras1N);
        r.casN = ~(~d.casLN | ~d.casUN);
        r.weN = d.aweN;
        r.bank1 = ~d.ras1N;
        r.bank0 = ~d.ras0N;
        r.clkEn = 1'b1;
        r.crcsN = 1'b0;
        r.ramEnN = 1'b1;
        r.cma = {1'b0, d.dra};
        return r;
    endfunction

    // Lane 0 is the upper lane and all enables are active low
    function automatic byteEnT expectedLanes(input logic cpuCyc, input logic dmaCyc);
        logic [3:0] lanes;
        lanes = 4'b1111;
        if (cpuCyc) begin
            if (cpu.siz == 2'b01) begin
                lanes = ~(4'b1000 >> cpu.addr[1:0]);
            end else if (cpu.siz == 2'b10) begin
                lanes = cpu.addr[1] ? 4'b1100 : 4'b0011;
            end else begin
                lanes = 4'b0000;
            end
        end else if (dmaCyc) begin
            lanes = {dma.casUN, dma.casUN, dma.casLN, dma.casLN};
        end
        return lanes;
    endfunction

    ////////////////////
    // Per cycle check
    ////////////////////

    task automatic checkOutputs;
        bufCtrlT expBuf;
        byteEnT  expBe;
        logic    dmaCyc;
        dmaCyc = ~mCpuCyc & ~dma.dbrN;
        expBuf.dbEnN = ~(mCpuCyc | dmaCyc);
        expBuf.vbEnN = ~mCpuCyc;
        expBuf.drdEnN = ~mRegAct;
        expBuf.dbDir = dmaCyc ? ~cpu.rnw : cpu.rnw;
        expBuf.drdDir = cpu.rnw;
        expBe = expectedLanes(mCpuCyc, dmaCyc);
        checks += 5;
        if (ram !== mRam) begin
            errors++;
            $display("FAILED %s ram: expected %h, actual %h", testName, mRam, ram);
        end
        if (strobe !== mStrobe) begin
            errors++;
            $display("FAILED %s strobe: expected %h, actual %h", testName, mStrobe, strobe);
        end
        if (bufCtrl !== expBuf) begin
            errors++;
            $display("FAILED %s bufCtrl: expected %h, actual %h", testName, expBuf, bufCtrl);
        end
        if (be !== expBe) begin
            errors++;
            $display("FAILED %s be: expected %h, actual %h", testName, expBe, be);
        end
        if (tackN !== mTackN) begin
            errors++;
            $display("FAILED %s tackN: expected %b, actual %b", testName, mTackN, tackN);
        end
    endtask

    // Check mid cycle and drive 2 ns after the edge
    task automatic stepCycle;
        @(negedge clk80);
        checkOutputs();
        @(posedge clk80);
        #2;
        cycleCnt++;
        c1Last = dma.c1;
        if (cycleCnt % 7 == 0) begin
            dma.c1 = ~dma.c1;
        end
    endtask

    ////////////////////
    // Bus master
    ////////////////////

    task automatic driveRequest(input logic isReg, input logic rnw, input logic [1:0] siz,
                                input logic [20:0] addr);
        cpu.tsN = 1'b0;
        cpu.rnw = rnw;
        cpu.siz = siz;
        cpu.addr = addr;
        cpu.regSpaceN = ~isReg;
        cpu.ramSpaceN = isReg;
    endtask

    task automatic releaseBus;
        cpu.tsN = 1'b1;
        cpu.rnw = 1'b1;
        cpu.regSpaceN = 1'b1;
        cpu.ramSpaceN = 1'b1;
    endtask

    task automatic regAccess(input logic rnw, input logic [1:0] siz, input logic [20:0] addr);
        int   n;
        int   lowCnt;
        logic rise;
        n = 0;
        rise = 1'b0;
        testName = $sformatf("regCycle siz %0d addr %h", siz, addr);
        dma.dbrN = 1'b1;
        driveRequest(1'b1, rnw, siz, addr);
        stepCycle();
        mRegAct = 1'b1;
        // Strobes start on the edge that sees c1 rise
        while (!rise && n < 28) begin
            rise = ~c1Last & dma.c1;
            stepCycle();
            n++;
        end
        mStrobe.asN = 1'b0;
        mStrobe.regEnN = 1'b0;
        if (siz == 2'b01) begin
            mStrobe.udsN = addr[0];
            mStrobe.ldsN = ~addr[0];
        end else begin
            mStrobe.udsN = 1'b0;
            mStrobe.ldsN = 1'b0;
        end
        n = 0;
        lowCnt = (strobe.asN === 1'b0) ? 1 : 0;
        while (tackN !== 1'b0 && n < 2 * `REG_STROBE_CYCLES) begin
            stepCycle();
            n++;
            if (strobe.asN === 1'b0) begin
                lowCnt++;
            end
            if (n == `REG_STROBE_CYCLES) begin
                mStrobe = '1;
            end
            if (n == `REG_STROBE_CYCLES + 1) begin
                mTackN = 1'b0;
            end
        end
        if (lowCnt != `REG_STROBE_CYCLES) begin
            errors++;
            $display("FAILED %s strobe length: expected %0d, actual %0d", testName,
                     `REG_STROBE_CYCLES, lowCnt);
        end
        if (n != `REG_STROBE_CYCLES + 1) begin
            errors++;
            $display("FAILED %s tackN delay: expected %0d, actual %0d", testName,
                     `REG_STROBE_CYCLES + 1, n);
        end
        // tsN goes up the cycle after tackN
        stepCycle();
        mTackN = 1'b1;
        mRegAct = 1'b0;
        releaseBus();
    endtask

    task automatic ramAccess(input logic rnw, input logic [1:0] siz, input logic [20:0] addr);
        int k;
        k = 0;
        testName = $sformatf("ramCycle rnw %b siz %0d addr %h", rnw, siz, addr);
        dma.dbrN = 1'b1;
        driveRequest(1'b0, rnw, siz, addr);
        stepCycle();
        mCpuCyc = 1'b1;
        mRam = ramIdle();
        mRam.clkEn = 1'b1;
        mRam.crcsN = 1'b0;
        mRam.ramEnN = 1'b0;
        while (tackN !== 1'b0 && k < 2 * RAM_LATENCY) begin
            stepCycle();
            k++;
            // Row and bank
            if (k == 1) begin
                mRam.rasN = 1'b0;
                mRam.cma = addr[`ROW_MSB:`ROW_LSB];
                mRam.bank1 = addr[`BANK_BIT];
                mRam.bank0 = ~addr[`BANK_BIT];
            end
            if (k == 1 + `RAS_TO_CAS) begin
                mRam.casN = 1'b0;
                mRam.cma = {3'b000, addr[`COL_MSB:`COL_LSB]};
                mRam.weN = rnw;
            end
            if (k == 1 + `RAS_TO_CAS + `CAS_CYCLES) begin
                mRam.rasN = 1'b1;
                mRam.casN = 1'b1;
                mRam.weN = 1'b1;
            end
            if (k == RAM_LATENCY) begin
                mTackN = 1'b0;
            end
        end
        if (k != RAM_LATENCY) begin
            errors++;
            $display("FAILED %s latency: expected %0d, actual %0d", testName, RAM_LATENCY, k);
        end
        stepCycle();
        mTackN = 1'b1;
        mCpuCyc = 1'b0;
        mRam = ramIdle();
        releaseBus();
    endtask

    // Agnus owns the RAM while a CPU RAM request may be left waiting
    task automatic dmaBurst(input int len, input logic pend, input logic rnw,
                            input logic [1:0] siz, input logic [20:0] addr);
        logic [31:0] r;
        int          i;
        testName = $sformatf("dmaBurst len %0d pend %b", len, pend);
        dma.dbrN = 1'b0;
        if (pend) begin
            driveRequest(1'b0, rnw, siz, addr);
        end
        for (i = 0; i <= len + 1; i++) begin
            // Strobes idle on the first and last clock of the grant
            if (i >= 1 && i <= len) begin
                drawRandom(r);
                dma.ras0N = r[0];
                dma.ras1N = r[1];
                dma.casLN = r[2];
                dma.casUN = r[3];
                dma.aweN = r[4];
                dma.dra = r[14:5];
            end else begin
                dma.ras0N = 1'b1;
                dma.ras1N = 1'b1;
                dma.casLN = 1'b1;
                dma.casUN = 1'b1;
                dma.aweN = 1'b1;
            end
            stepCycle();
            mRam = forwarded(dma);
            if (pend && ram.ramEnN === 1'b0) begin
                errors++;
                $display("%s: CPU RAM cycle started while dbrN was low", testName);
            end
        end
        if (!pend) begin
            dma.dbrN = 1'b1;
            stepCycle();
            mRam = ramIdle();
        end
    endtask

    ////////////////////
    // Main sequence
    ////////////////////

    initial begin
        logic [31:0] r1;
        logic [31:0] r2;
        int          t;
        int          kind;
        cpu = '0;
        releaseBus();
        dma = '1;
        dma.dra = '0;
        dma.c1 = 1'b0;
        mRam = ramIdle();
        mStrobe = '1;
        mTackN = 1'b1;
        mCpuCyc = 1'b0;
        mRegAct = 1'b0;
        rngState = 32'd18907;
        c1Last = 1'b0;
        cycleCnt = 0;
        errors = 0;
        checks = 0;
        @(posedge clk80);
        #2;
        // Reset window plus two idle clocks
        testName = "reset";
        repeat (12) stepCycle();
        for (t = 0; t < NUM_TRANS; t++) begin
            drawRandom(r1);
            drawRandom(r2);
            kind = int'(r1 % 3);
            if (kind == 0) begin
                regAccess(r1[4], r1[6:5], r2[20:0]);
            end else if (kind == 1) begin
                ramAccess(r1[4], r1[6:5], r2[20:0]);
            end else begin
                dmaBurst(1 + int'(r1[10:8]), r1[11], r1[4], r1[6:5], r2[20:0]);
                // Waiting request runs once dbrN is back high
                if (r1[11]) begin
                    ramAccess(r1[4], r1[6:5], r2[20:0]);
                end
            end
            testName = "idle";
            repeat (int'(r1[31:30])) stepCycle();
        end
        $display("Checks %0d, errors %0d", checks, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

    // Watchdog
    initial begin
        repeat (MAX_CYCLES) @(posedge clk80);
        $display("Run timed out after %0d cycles", MAX_CYCLES);
        $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+.
u712Pkg.sv
regCycle.sv
chipRam.sv
byteEnable.sv
busControl.sv
u712Top.sv
tbClock.sv
u712Tb.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing -j 0
TOP       := u712Tb
FILELIST  := verilog.f
OBJDIR    := obj_dir
SIM       := $(OBJDIR)/V$(TOP)
LOG       := sim.log
SOURCES   := $(shell grep -v '^+' $(FILELIST)) u712Config.svh

.PHONY: all run clean

all: run

# Rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJDIR) -f $(FILELIST)

# Pass only when the log holds the pass message
run: $(SIM)
	./$(SIM) | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJDIR) $(LOG)
